/* tb/udp_rx_golden.txt */
// frame: bp ip_length ip_protocol ip_source_ip ip_dest_ip, n_in and input bytes (tlast on last)
// then source_port dest_port length checksum, n_out and output bytes, tuser hdr_err pl_err
07 // number of frames
0 0022 11 c0a80001 c0a80064
0e 04 d2 16 2e 00 0e 5a 3c 11 22 33 44 55 66
04d2 162e 000e 5a3c 06 11 22 33 44 55 66 0 0 0
0 0025 11 0a000001 0a000002
11 13 88 00 35 00 0c 00 00 a1 b2 c3 d4 00 00 00 00 00
1388 0035 000c 0000 04 a1 b2 c3 d4 0 0 0
0 0026 11 ac100005 ac10000a
0d 1f 90 1f 91 00 12 be ef 01 02 03 04 05
1f90 1f91 0012 beef 05 01 02 03 04 05 1 0 1
0 0030 11 c0a80101 ffffffff
05 00 44 00 43 00
0000 0000 0000 0000 00 0 1 0
1 0023 11 0a0a0a0a 0a0a0a0b
0f 30 39 d4 31 00 0f 12 34 de ad be ef ca fe 42
3039 d431 000f 1234 07 de ad be ef ca fe 42 0 0 0
1 0022 11 c0000201 c0000202
0e 00 07 00 07 00 0b ab cd 99 88 77 00 00 00
0007 0007 000b abcd 03 99 88 77 0 0 0
1 0024 11 08080808 08080404
0b 00 50 c3 50 00 10 00 01 0f 1e 2d
0050 c350 0010 0001 03 0f 1e 2d 1 0 1

/* src.f */
common/udp_rx_pkg.sv
udp_rx/udp_rx_ctrl.sv
hdl/axis_skid_buf.sv
hdl/udp_ip_rx.sv
tb/tb_udp_ip_rx.sv

/* Bender.yml */
package:
  name: udp_ip_rx

sources:
  - files:
      - common/udp_rx_pkg.sv
      - udp_rx/udp_rx_ctrl.sv
      - hdl/axis_skid_buf.sv
      - hdl/udp_ip_rx.sv
  - target: test
    files:
      - tb/tb_udp_ip_rx.sv

/* tb/tb_udp_ip_rx.sv */
`default_nettype none

/*
 * UDP receiver testbench
 * replays golden frames and checks headers, payload beats and status outputs
 */
module tb_udp_ip_rx;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int GOLD_WORDS = 1024;
    localparam int MAX_FRAMES = 32;
    localparam int MAX_BYTES  = 512;

    logic clk;
    logic rst;

    udp_rx_pkg::ip_hdr_t    s_ip_hdr;
    logic                   s_ip_hdr_valid;
    logic                   s_ip_hdr_ready;
    udp_rx_pkg::axis_beat_t s_ip_payload;
    logic                   s_ip_payload_tvalid;
    logic                   s_ip_payload_tready;
    udp_rx_pkg::udp_hdr_t   m_udp_hdr;
    logic                   m_udp_hdr_valid;
    logic                   m_udp_hdr_ready;
    udp_rx_pkg::axis_beat_t m_udp_payload;
    logic                   m_udp_payload_tvalid;
    logic                   m_udp_payload_tready;
    logic                   busy;
    logic                   error_header_early_termination;
    logic                   error_payload_early_termination;

    // golden records unpacked per frame
    logic [31:0]          gold [0:GOLD_WORDS-1];
    int                   n_frames;
    logic                 bp_mode   [0:MAX_FRAMES-1];
    udp_rx_pkg::ip_hdr_t  frame_ip  [0:MAX_FRAMES-1];
    udp_rx_pkg::udp_hdr_t frame_exp [0:MAX_FRAMES-1];
    int                   in_start  [0:MAX_FRAMES-1];
    int                   in_len    [0:MAX_FRAMES-1];
    int                   out_start [0:MAX_FRAMES-1];
    int                   out_len   [0:MAX_FRAMES-1];
    logic                 exp_tuser [0:MAX_FRAMES-1];
    logic                 exp_herr  [0:MAX_FRAMES-1];
    logic                 exp_perr  [0:MAX_FRAMES-1];
    udp_rx_pkg::byte_t    in_bytes  [0:MAX_BYTES-1];
    udp_rx_pkg::byte_t    out_bytes [0:MAX_BYTES-1];

    // frames that should come out in order
    int expect_q[$];

    int total_bytes   = 0;
    int herr_expected = 0;
    int perr_expected = 0;
    int herr_pulses   = 0;
    int perr_pulses   = 0;
    int hdr_pos       = 0;
    int pay_pos       = 0;
    int byte_pos      = 0;
    int cycle_count   = 0;
    int cycle_limit   = 0;
    logic bp_active   = 1'b0;

    udp_ip_rx DUT (
        .clk                             (clk),
        .rst                             (rst),
        .s_ip_hdr                        (s_ip_hdr),
        .s_ip_hdr_valid                  (s_ip_hdr_valid),
        .s_ip_hdr_ready                  (s_ip_hdr_ready),
        .s_ip_payload                    (s_ip_payload),
        .s_ip_payload_tvalid             (s_ip_payload_tvalid),
        .s_ip_payload_tready             (s_ip_payload_tready),
        .m_udp_hdr                       (m_udp_hdr),
        .m_udp_hdr_valid                 (m_udp_hdr_valid),
        .m_udp_hdr_ready                 (m_udp_hdr_ready),
        .m_udp_payload                   (m_udp_payload),
        .m_udp_payload_tvalid            (m_udp_payload_tvalid),
        .m_udp_payload_tready            (m_udp_payload_tready),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected)
        else fail_run($sformatf("[ERROR] t=%0t %s expected 0x%0h got 0x%0h",
                                $time, name, expected, actual));
    endtask

    task automatic check_pulse(input string name, input logic actual, input logic expected,
                               input int f);
        if (expected) begin
            assert (actual === 1'b1)
            else fail_run($sformatf("%s did not pulse at the end of frame %0d", name, f));
        end else begin
            check_value(name, actual, 32'd0);
        end
    endtask

    task automatic load_golden();
        int p;
        int in_fill;
        int out_fill;
        p = 1;
        in_fill = 0;
        out_fill = 0;
        $readmemh("tb/udp_rx_golden.txt", gold);
        n_frames = int'(gold[0]);
        assert (n_frames > 0 && n_frames <= MAX_FRAMES)
        else fail_run("golden file could not be read or holds no valid frame count");
        for (int f = 0; f < n_frames; f++) begin
            bp_mode[f]               = gold[p][0];
            frame_ip[f].ip_length    = gold[p + 1][15:0];
            frame_ip[f].ip_protocol  = gold[p + 2][7:0];
            frame_ip[f].ip_source_ip = gold[p + 3];
            frame_ip[f].ip_dest_ip   = gold[p + 4];
            p = p + 5;
            in_len[f]   = int'(gold[p]);
            in_start[f] = in_fill;
            p = p + 1;
            for (int i = 0; i < in_len[f]; i++) begin
                in_bytes[in_fill] = gold[p][7:0];
                in_fill = in_fill + 1;
                p = p + 1;
            end
            // retained IP fields pass through unchanged
            frame_exp[f].ip          = frame_ip[f];
            frame_exp[f].source_port = gold[p][15:0];
            frame_exp[f].dest_port   = gold[p + 1][15:0];
            frame_exp[f].length      = gold[p + 2][15:0];
            frame_exp[f].checksum    = gold[p + 3][15:0];
            p = p + 4;
            out_len[f]   = int'(gold[p]);
            out_start[f] = out_fill;
            p = p + 1;
            for (int i = 0; i < out_len[f]; i++) begin
                out_bytes[out_fill] = gold[p][7:0];
                out_fill = out_fill + 1;
                p = p + 1;
            end
            exp_tuser[f] = gold[p][0];
            exp_herr[f]  = gold[p + 1][0];
            exp_perr[f]  = gold[p + 2][0];
            p = p + 3;
            total_bytes   = total_bytes + in_len[f];
            herr_expected = herr_expected + int'(exp_herr[f]);
            perr_expected = perr_expected + int'(exp_perr[f]);
            if (!exp_herr[f]) begin
                expect_q.push_back(f);
            end
        end
    endtask

    task automatic send_frame(input int f);
        udp_rx_pkg::axis_beat_t beat;
        bp_active      = bp_mode[f];
        s_ip_hdr       = frame_ip[f];
        s_ip_hdr_valid = 1'b1;
        while (!s_ip_hdr_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        s_ip_hdr_valid = 1'b0;
        check_value("busy", busy, 32'd1);
        for (int i = 0; i < in_len[f]; i++) begin
            beat.tdata          = in_bytes[in_start[f] + i];
            beat.tlast          = (i == in_len[f] - 1);
            beat.tuser          = 1'b0;
            s_ip_payload        = beat;
            s_ip_payload_tvalid = 1'b1;
            while (!s_ip_payload_tready) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
        end
        s_ip_payload_tvalid = 1'b0;
        // error flags land the cycle after tlast is taken
        check_pulse("error_header_early_termination", error_header_early_termination,
                    exp_herr[f], f);
        check_pulse("error_payload_early_termination", error_payload_early_termination,
                    exp_perr[f], f);
    endtask

    task automatic check_header();
        int f;
        assert (hdr_pos < expect_q.size())
        else fail_run("a UDP header came out although no further frame was expected");
        f = expect_q[hdr_pos];
        check_value("m_udp_hdr.ip.ip_length", m_udp_hdr.ip.ip_length, frame_exp[f].ip.ip_length);
        check_value("m_udp_hdr.ip.ip_protocol", m_udp_hdr.ip.ip_protocol,
                    frame_exp[f].ip.ip_protocol);
        check_value("m_udp_hdr.ip.ip_source_ip", m_udp_hdr.ip.ip_source_ip,
                    frame_exp[f].ip.ip_source_ip);
        check_value("m_udp_hdr.ip.ip_dest_ip", m_udp_hdr.ip.ip_dest_ip,
                    frame_exp[f].ip.ip_dest_ip);
        check_value("m_udp_hdr.source_port", m_udp_hdr.source_port, frame_exp[f].source_port);
        check_value("m_udp_hdr.dest_port", m_udp_hdr.dest_port, frame_exp[f].dest_port);
        check_value("m_udp_hdr.length", m_udp_hdr.length, frame_exp[f].length);
        check_value("m_udp_hdr.checksum", m_udp_hdr.checksum, frame_exp[f].checksum);
        hdr_pos = hdr_pos + 1;
    endtask

    task automatic check_beat();
        int f;
        int last_idx;
        assert (pay_pos < expect_q.size())
        else fail_run("a payload beat came out although no further frame was expected");
        f = expect_q[pay_pos];
        last_idx = out_len[f] - 1;
        check_value("m_udp_payload.tdata", m_udp_payload.tdata,
                    out_bytes[out_start[f] + byte_pos]);
        check_value("m_udp_payload.tlast", m_udp_payload.tlast, byte_pos == last_idx);
        check_value("m_udp_payload.tuser", m_udp_payload.tuser,
                    (byte_pos == last_idx) ? exp_tuser[f] : 1'b0);
        if (byte_pos == last_idx) begin
            byte_pos = 0;
            pay_pos  = pay_pos + 1;
        end else begin
            byte_pos = byte_pos + 1;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (error_header_early_termination) begin
                herr_pulses = herr_pulses + 1;
            end
            if (error_payload_early_termination) begin
                perr_pulses = perr_pulses + 1;
            end
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                check_header();
            end
            if (m_udp_payload_tvalid && m_udp_payload_tready) begin
                check_beat();
            end
        end
    end

    // sink readiness is random in back-pressure frames
    initial begin
        int seed;
        int seed_discard;
        seed = 10202;
        seed_discard = $urandom(seed);
        forever begin
            @(posedge clk);
            #1;
            if (bp_active) begin
                m_udp_payload_tready = ($urandom % 3) != 0;
                m_udp_hdr_ready      = ($urandom % 2) != 0;
            end else begin
                m_udp_payload_tready = 1'b1;
                m_udp_hdr_ready      = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, frames did not complete", cycle_count));
        end
    end

    initial begin
        rst                  = 1'b1;
        s_ip_hdr             = '0;
        s_ip_hdr_valid       = 1'b0;
        s_ip_payload         = '0;
        s_ip_payload_tvalid  = 1'b0;
        m_udp_hdr_ready      = 1'b1;
        m_udp_payload_tready = 1'b1;
        load_golden();
        cycle_limit = 40 * total_bytes + 200;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("s_ip_hdr_ready", s_ip_hdr_ready, 32'd0);
        check_value("s_ip_payload_tready", s_ip_payload_tready, 32'd0);
        check_value("m_udp_hdr_valid", m_udp_hdr_valid, 32'd0);
        check_value("m_udp_payload_tvalid", m_udp_payload_tvalid, 32'd0);
        check_value("busy", busy, 32'd0);
        check_value("error_header_early_termination", error_header_early_termination, 32'd0);
        check_value("error_payload_early_termination", error_payload_early_termination, 32'd0);
        @(posedge clk);
        #1;
        check_value("s_ip_hdr_ready", s_ip_hdr_ready, 32'd1);

        for (int f = 0; f < n_frames; f++) begin
            send_frame(f);
        end

        // let the output side drain
        while (hdr_pos < expect_q.size() || pay_pos < expect_q.size()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
        check_value("busy", busy, 32'd0);
        assert (herr_pulses == herr_expected)
        else fail_run($sformatf("saw %0d header early termination pulses, expected %0d",
                                herr_pulses, herr_expected));
        assert (perr_pulses == perr_expected)
        else fail_run($sformatf("saw %0d payload early termination pulses, expected %0d",
                                perr_pulses, perr_expected));
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/udp_ip_rx.sv */
`default_nettype none

/*
 * UDP receiver top level
 * IP header plus payload stream in, UDP header plus payload stream out
 */
module udp_ip_rx (
    input  wire logic                   clk,
    input  wire logic                   rst,

    // IP frame in
    input  wire udp_rx_pkg::ip_hdr_t    s_ip_hdr,
    input  wire logic                   s_ip_hdr_valid,
    output wire logic                   s_ip_hdr_ready,
    input  wire udp_rx_pkg::axis_beat_t s_ip_payload,
    input  wire logic                   s_ip_payload_tvalid,
    output wire logic                   s_ip_payload_tready,

    // UDP frame out
    output wire udp_rx_pkg::udp_hdr_t   m_udp_hdr,
    output wire logic                   m_udp_hdr_valid,
    input  wire logic                   m_udp_hdr_ready,
    output wire udp_rx_pkg::axis_beat_t m_udp_payload,
    output wire logic                   m_udp_payload_tvalid,
    input  wire logic                   m_udp_payload_tready,

    // status
    output wire logic                   busy,
    output wire logic                   error_header_early_termination,
    output wire logic                   error_payload_early_termination
);

    // controller to output stage
    wire udp_rx_pkg::axis_beat_t int_beat;
    wire logic                   int_valid;
    wire logic                   ready_early;

    udp_rx_ctrl u_ctrl (
        .clk                             (clk),
        .rst                             (rst),
        .s_ip_hdr                        (s_ip_hdr),
        .s_ip_hdr_valid                  (s_ip_hdr_valid),
        .s_ip_hdr_ready                  (s_ip_hdr_ready),
        .s_ip_payload                    (s_ip_payload),
        .s_ip_payload_tvalid             (s_ip_payload_tvalid),
        .s_ip_payload_tready             (s_ip_payload_tready),
        .m_udp_hdr                       (m_udp_hdr),
        .m_udp_hdr_valid                 (m_udp_hdr_valid),
        .m_udp_hdr_ready                 (m_udp_hdr_ready),
        .int_beat                        (int_beat),
        .int_valid                       (int_valid),
        .ready_early                     (ready_early),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    axis_skid_buf u_skid (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (int_beat),
        .in_valid    (int_valid),
        .ready_early (ready_early),
        .out_beat    (m_udp_payload),
        .out_valid   (m_udp_payload_tvalid),
        .out_ready   (m_udp_payload_tready)
    );

endmodule

`default_nettype wire

/* hdl/axis_skid_buf.sv */
`default_nettype none

/*
 * Stream skid buffer
 * registered output plus one holding register so upstream ready can be registered
 */
module axis_skid_buf (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire udp_rx_pkg::axis_beat_t in_beat,
    input  wire logic                   in_valid,
    output logic                        ready_early,

    output udp_rx_pkg::axis_beat_t      out_beat,
    output logic                        out_valid,
    input  wire logic                   out_ready
);

    logic ready_reg;
    logic out_valid_reg, out_valid_next;
    logic temp_valid_reg, temp_valid_next;

    udp_rx_pkg::axis_beat_t out_beat_reg;
    udp_rx_pkg::axis_beat_t temp_beat_reg;

    logic load_out;
    logic load_temp;
    logic temp_to_out;

    // ready next cycle unless the holding register could fill up
    assign ready_early = out_ready || (!temp_valid_reg && (!out_valid_reg || !in_valid));

    assign out_beat  = out_beat_reg;
    assign out_valid = out_valid_reg;

    always_comb begin
        out_valid_next  = out_valid_reg;
        temp_valid_next = temp_valid_reg;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;

        if (ready_reg) begin
            if (out_ready || !out_valid_reg) begin
                out_valid_next = in_valid;
                load_out       = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = in_valid;
                load_temp       = 1'b1;
            end
        end else if (out_ready) begin
            // upstream held off, drain the parked beat
            out_valid_next  = temp_valid_reg;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg      <= 1'b0;
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
        end else begin
            ready_reg      <= ready_early;
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_beat_reg <= in_beat;
        end else if (temp_to_out) begin
            out_beat_reg <= temp_beat_reg;
        end
        if (load_temp) begin
            temp_beat_reg <= in_beat;
        end
    end

endmodule

`default_nettype wire

/* udp_rx/udp_rx_ctrl.sv */
`default_nettype none

/*
 * UDP receive controller
 * takes the IP header, assembles the UDP header from the first eight payload
 * bytes, then passes the UDP payload on and drops any IP padding after it
 */
module udp_rx_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire udp_rx_pkg::ip_hdr_t  s_ip_hdr,
    input  wire logic                 s_ip_hdr_valid,
    output logic                      s_ip_hdr_ready,

    input  wire udp_rx_pkg::axis_beat_t s_ip_payload,
    input  wire logic                 s_ip_payload_tvalid,
    output logic                      s_ip_payload_tready,

    output udp_rx_pkg::udp_hdr_t      m_udp_hdr,
    output logic                      m_udp_hdr_valid,
    input  wire logic                 m_udp_hdr_ready,

    output udp_rx_pkg::axis_beat_t    int_beat,
    output logic                      int_valid,
    input  wire logic                 ready_early,

    output logic                      busy,
    output logic                      error_header_early_termination,
    output logic                      error_payload_early_termination
);

    udp_rx_pkg::rx_state_t state_reg, state_next;

    // datapath strobes
    logic store_ip_hdr;
    logic store_hdr_byte;
    logic store_last_byte;

    logic [2:0]        hdr_ptr_reg, hdr_ptr_next;
    udp_rx_pkg::len_t  word_count_reg, word_count_next;
    udp_rx_pkg::byte_t last_byte_reg;
    udp_rx_pkg::udp_hdr_t hdr_reg;

    logic hdr_valid_reg, hdr_valid_next;
    logic hdr_ready_reg, hdr_ready_next;
    logic pl_ready_reg, pl_ready_next;
    logic busy_reg;
    logic err_hdr_reg, err_hdr_next;
    logic err_pl_reg, err_pl_next;

    logic pl_fire;

    assign pl_fire = pl_ready_reg && s_ip_payload_tvalid;

    assign s_ip_hdr_ready      = hdr_ready_reg;
    assign s_ip_payload_tready = pl_ready_reg;
    assign m_udp_hdr           = hdr_reg;
    assign m_udp_hdr_valid     = hdr_valid_reg;
    assign busy                = busy_reg;

    assign error_header_early_termination  = err_hdr_reg;
    assign error_payload_early_termination = err_pl_reg;

    always_comb begin
        state_next      = udp_rx_pkg::st_idle;
        hdr_ready_next  = 1'b0;
        pl_ready_next   = 1'b0;
        store_ip_hdr    = 1'b0;
        store_hdr_byte  = 1'b0;
        store_last_byte = 1'b0;
        hdr_ptr_next    = hdr_ptr_reg;
        word_count_next = word_count_reg;
        err_hdr_next    = 1'b0;
        err_pl_next     = 1'b0;

        // header stays valid until the sink takes it
        hdr_valid_next = hdr_valid_reg && !m_udp_hdr_ready;

        int_beat  = s_ip_payload;
        int_valid = 1'b0;

        case (state_reg)
            udp_rx_pkg::st_idle: begin
                hdr_ptr_next   = 3'd0;
                hdr_ready_next = !hdr_valid_next;
                state_next     = udp_rx_pkg::st_idle;
                if (hdr_ready_reg && s_ip_hdr_valid) begin
                    hdr_ready_next = 1'b0;
                    pl_ready_next  = 1'b1;
                    store_ip_hdr   = 1'b1;
                    state_next     = udp_rx_pkg::st_read_header;
                end
            end

            udp_rx_pkg::st_read_header: begin
                pl_ready_next   = 1'b1;
                // length bytes are in place well before the last header byte
                word_count_next = hdr_reg.length
                                  - udp_rx_pkg::len_t'(udp_rx_pkg::UDP_HDR_BYTES);
                state_next      = udp_rx_pkg::st_read_header;
                if (pl_fire) begin
                    store_hdr_byte = 1'b1;
                    hdr_ptr_next   = hdr_ptr_reg + 3'd1;
                    if (hdr_ptr_reg == 3'd7) begin
                        hdr_valid_next = 1'b1;
                        pl_ready_next  = ready_early;
                        state_next     = udp_rx_pkg::st_read_payload;
                    end
                    if (s_ip_payload.tlast) begin
                        // frame ended inside the UDP header
                        err_hdr_next   = 1'b1;
                        hdr_valid_next = 1'b0;
                        hdr_ready_next = !hdr_valid_next;
                        pl_ready_next  = 1'b0;
                        state_next     = udp_rx_pkg::st_idle;
                    end
                end
            end

            udp_rx_pkg::st_read_payload: begin
                pl_ready_next = ready_early;
                state_next    = udp_rx_pkg::st_read_payload;
                if (pl_fire) begin
                    word_count_next = word_count_reg - 16'd1;
                    int_valid       = 1'b1;
                    if (s_ip_payload.tlast) begin
                        if (word_count_reg != 16'd1) begin
                            // short payload, flag it on the final beat
                            int_beat.tuser = 1'b1;
                            err_pl_next    = 1'b1;
                        end
                        hdr_ready_next = !hdr_valid_next;
                        pl_ready_next  = 1'b0;
                        state_next     = udp_rx_pkg::st_idle;
                    end else if (word_count_reg == 16'd1) begin
                        // padding follows, keep the byte until tlast shows up
                        store_last_byte = 1'b1;
                        int_valid       = 1'b0;
                        state_next      = udp_rx_pkg::st_read_payload_last;
                    end
                end
            end

            udp_rx_pkg::st_read_payload_last: begin
                pl_ready_next  = ready_early;
                int_beat.tdata = last_byte_reg;
                state_next     = udp_rx_pkg::st_read_payload_last;
                if (pl_fire && s_ip_payload.tlast) begin
                    int_valid      = 1'b1;
                    hdr_ready_next = !hdr_valid_next;
                    pl_ready_next  = 1'b0;
                    state_next     = udp_rx_pkg::st_idle;
                end
            end

            default: begin
                state_next = udp_rx_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg      <= udp_rx_pkg::st_idle;
            hdr_ready_reg  <= 1'b0;
            pl_ready_reg   <= 1'b0;
            hdr_valid_reg  <= 1'b0;
            busy_reg       <= 1'b0;
            err_hdr_reg    <= 1'b0;
            err_pl_reg     <= 1'b0;
            hdr_ptr_reg    <= 3'd0;
            word_count_reg <= '0;
        end else begin
            state_reg      <= state_next;
            hdr_ready_reg  <= hdr_ready_next;
            pl_ready_reg   <= pl_ready_next;
            hdr_valid_reg  <= hdr_valid_next;
            busy_reg       <= state_next != udp_rx_pkg::st_idle;
            err_hdr_reg    <= err_hdr_next;
            err_pl_reg     <= err_pl_next;
            hdr_ptr_reg    <= hdr_ptr_next;
            word_count_reg <= word_count_next;
        end
    end

    // header and held byte storage
    always_ff @(posedge clk) begin
        if (store_ip_hdr) begin
            hdr_reg.ip <= s_ip_hdr;
        end
        if (store_last_byte) begin
            last_byte_reg <= s_ip_payload.tdata;
        end
        if (store_hdr_byte) begin
            // network order, high byte first
            case (hdr_ptr_reg)
                3'd0: hdr_reg.source_port[15:8] <= s_ip_payload.tdata;
                3'd1: hdr_reg.source_port[7:0]  <= s_ip_payload.tdata;
                3'd2: hdr_reg.dest_port[15:8]   <= s_ip_payload.tdata;
                3'd3: hdr_reg.dest_port[7:0]    <= s_ip_payload.tdata;
                3'd4: hdr_reg.length[15:8]      <= s_ip_payload.tdata;
                3'd5: hdr_reg.length[7:0]       <= s_ip_payload.tdata;
                3'd6: hdr_reg.checksum[15:8]    <= s_ip_payload.tdata;
                3'd7: hdr_reg.checksum[7:0]     <= s_ip_payload.tdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/udp_rx_pkg.sv */
`default_nettype none

/*
 * UDP receiver shared types
 * field widths, header structs, the stream beat and controller states
 */
package udp_rx_pkg;

    // plain field widths
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;

    // UDP header length on the wire, in bytes
    localparam int UDP_HDR_BYTES = 8;

    // IP fields carried through to the UDP side
    typedef struct packed {
        len_t     ip_length;
        byte_t    ip_protocol;
        ip_addr_t ip_source_ip;
        ip_addr_t ip_dest_ip;
    } ip_hdr_t;

    // full UDP header as presented downstream
    typedef struct packed {
        ip_hdr_t     ip;
        port_t       source_port;
        port_t       dest_port;
        len_t        length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // one byte-wide stream beat
    typedef struct packed {
        byte_t tdata;
        logic  tlast;
        logic  tuser;
    } axis_beat_t;

    // receive controller states
    typedef enum logic [1:0] {
        st_idle,
        st_read_header,
        st_read_payload,
        st_read_payload_last
    } rx_state_t;

endpackage

`default_nettype wire
